/* source/arcade_ctrl_pkg.sv */
`default_nettype none

package arcade_ctrl_pkg;

	// scan fsm position inside a prefixed sequence
	typedef enum logic [1:0] {
		scan_idle      = 2'd0,
		scan_ext       = 2'd1,   // E0 seen
		scan_break     = 2'd2,   // F0 seen
		scan_ext_break = 2'd3    // E0 then F0
	} scan_state_t;

	// bit positions in the cabinet button vector
	typedef enum logic [2:0] {
		btn_up     = 3'd0,
		btn_down   = 3'd1,
		btn_left   = 3'd2,
		btn_right  = 3'd3,
		btn_fire   = 3'd4,
		btn_coin   = 3'd5,
		btn_start1 = 3'd6,
		btn_start2 = 3'd7
	} button_t;

	// ps/2 set 2 prefixes
	localparam logic [7:0] SC_EXT   = 8'hE0;
	localparam logic [7:0] SC_BREAK = 8'hF0;

	// key codes, arrows need the E0 prefix
	localparam logic [7:0] SC_UP    = 8'h75;
	localparam logic [7:0] SC_DOWN  = 8'h72;
	localparam logic [7:0] SC_LEFT  = 8'h6B;
	localparam logic [7:0] SC_RIGHT = 8'h74;
	localparam logic [7:0] SC_ESC   = 8'h76;
	localparam logic [7:0] SC_F1    = 8'h05;
	localparam logic [7:0] SC_F2    = 8'h06;
	localparam logic [7:0] SC_SPACE = 8'h29;

endpackage

`default_nettype wire

/* source/scan_code_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module scan_code_fsm (
	input  wire logic       clk_mist,
	input  wire logic       reset,
	input  wire logic [7:0] scan_byte,
	input  wire logic       scan_valid,
	output logic            key_strobe,
	output logic      [7:0] key_code,
	output logic            key_pressed,
	output logic            key_extended
);

	arcade_ctrl_pkg::scan_state_t state;
	arcade_ctrl_pkg::scan_state_t state_next;
	logic seen_ext;
	logic seen_break;
	logic is_final;

	always_comb begin
		seen_ext   = 1'b0;
		seen_break = 1'b0;
		case (state)
			arcade_ctrl_pkg::scan_ext: begin
				seen_ext = 1'b1;
			end
			arcade_ctrl_pkg::scan_break: begin
				seen_break = 1'b1;
			end
			arcade_ctrl_pkg::scan_ext_break: begin
				seen_ext   = 1'b1;
				seen_break = 1'b1;
			end
			default: begin
				seen_ext   = 1'b0;
				seen_break = 1'b0;
			end
		endcase
	end

	always_comb begin
		state_next = state;
		is_final   = 1'b0;
		if (scan_valid) begin
			case (scan_byte)
				arcade_ctrl_pkg::SC_EXT: begin
					state_next = arcade_ctrl_pkg::scan_ext;
				end
				arcade_ctrl_pkg::SC_BREAK: begin
					if (seen_ext)
						state_next = arcade_ctrl_pkg::scan_ext_break;
					else
						state_next = arcade_ctrl_pkg::scan_break;
				end
				default: begin
					state_next = arcade_ctrl_pkg::scan_idle; // sequence done
					is_final   = 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk_mist) begin
		if (reset) begin
			state      <= arcade_ctrl_pkg::scan_idle;
			key_strobe <= 1'b0;
		end else begin
			state      <= state_next;
			key_strobe <= is_final; // prefixes give no event
		end
	end

	// event payload
	always_ff @(posedge clk_mist) begin
		if (reset) begin
			key_code     <= 8'h00;
			key_pressed  <= 1'b0;
			key_extended <= 1'b0;
		end else if (is_final) begin
			key_code     <= scan_byte;
			key_pressed  <= ~seen_break;
			key_extended <= seen_ext;
		end
	end

endmodule

`default_nettype wire

/* source/key_button_latch.sv */
`timescale 1ns/100ps
`default_nettype none

module key_button_latch (
	input  wire logic       clk_mist,
	input  wire logic       reset,
	input  wire logic       key_strobe,
	input  wire logic [7:0] key_code,
	input  wire logic       key_pressed,
	input  wire logic       key_extended,
	output logic      [7:0] buttons
);

	always_ff @(posedge clk_mist) begin
		if (reset) begin
			buttons <= 8'h00;
		end else if (key_strobe) begin
			if (key_extended) begin
				// cursor block
				case (key_code)
					arcade_ctrl_pkg::SC_UP: begin
						buttons[arcade_ctrl_pkg::btn_up] <= key_pressed;
					end
					arcade_ctrl_pkg::SC_DOWN: begin
						buttons[arcade_ctrl_pkg::btn_down] <= key_pressed;
					end
					arcade_ctrl_pkg::SC_LEFT: begin
						buttons[arcade_ctrl_pkg::btn_left] <= key_pressed;
					end
					arcade_ctrl_pkg::SC_RIGHT: begin
						buttons[arcade_ctrl_pkg::btn_right] <= key_pressed;
					end
					default: begin
						buttons <= buttons; // unlisted, hold
					end
				endcase
			end else begin
				case (key_code)
					arcade_ctrl_pkg::SC_ESC: begin
						buttons[arcade_ctrl_pkg::btn_coin] <= key_pressed;
					end
					arcade_ctrl_pkg::SC_F1: begin
						buttons[arcade_ctrl_pkg::btn_start1] <= key_pressed;
					end
					arcade_ctrl_pkg::SC_F2: begin
						buttons[arcade_ctrl_pkg::btn_start2] <= key_pressed;
					end
					arcade_ctrl_pkg::SC_SPACE: begin
						buttons[arcade_ctrl_pkg::btn_fire] <= key_pressed;
					end
					default: begin
						buttons <= buttons; // keypad 8 etc, ignore
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* source/coin_pulse_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module coin_pulse_timer #(
	parameter int unsigned COIN_CYCLES = 16
) (
	input  wire logic clk_mist,
	input  wire logic reset,
	input  wire logic coin_button,
	output logic      coin
);

	localparam logic [7:0] LOAD_VALUE = 8'(COIN_CYCLES);

	logic       coin_button_d;
	logic       coin_rise;
	logic [7:0] count;

	assign coin_rise = coin_button & ~coin_button_d;

	always_ff @(posedge clk_mist) begin
		if (reset) begin
			coin_button_d <= 1'b0;
		end else begin
			coin_button_d <= coin_button;
		end
	end

	// retrigger only once the running pulse is over
	always_ff @(posedge clk_mist) begin
		if (reset) begin
			count <= 8'd0;
		end else if (coin_rise && count == 8'd0) begin
			count <= LOAD_VALUE;
		end else if (count != 8'd0) begin
			count <= count - 8'd1;
		end
	end

	assign coin = (count != 8'd0);

endmodule

`default_nettype wire

/* source/control_mapper.sv */
`timescale 1ns/100ps
`default_nettype none

module control_mapper (
	input  wire logic [7:0] buttons,
	input  wire logic [7:0] joystick_0,
	input  wire logic [7:0] joystick_1,
	input  wire logic       rotate,
	output logic            up,
	output logic            down,
	output logic            left,
	output logic            right,
	output logic            fire,
	output logic            start1,
	output logic            start2
);

	logic src_up;
	logic src_down;
	logic src_left;
	logic src_right;

	// joystick bits: 0 right, 1 left, 2 down, 3 up, 4 fire
	assign src_up    = buttons[arcade_ctrl_pkg::btn_up]
	                 | joystick_0[3] | joystick_1[3];
	assign src_down  = buttons[arcade_ctrl_pkg::btn_down]
	                 | joystick_0[2] | joystick_1[2];
	assign src_left  = buttons[arcade_ctrl_pkg::btn_left]
	                 | joystick_0[1] | joystick_1[1];
	assign src_right = buttons[arcade_ctrl_pkg::btn_right]
	                 | joystick_0[0] | joystick_1[0];

	// rotated cabinet, quarter turn
	assign up    = rotate ? src_right : src_up;
	assign down  = rotate ? src_left  : src_down;
	assign left  = rotate ? src_up    : src_left;
	assign right = rotate ? src_down  : src_right;

	assign fire = buttons[arcade_ctrl_pkg::btn_fire] | joystick_0[4] | joystick_1[4];

	assign start1 = buttons[arcade_ctrl_pkg::btn_start1];
	assign start2 = buttons[arcade_ctrl_pkg::btn_start2];

endmodule

`default_nettype wire

/* source/arcade_controls_top.sv */
`timescale 1ns/100ps
`default_nettype none

module arcade_controls_top #(
	parameter int unsigned COIN_CYCLES = 16
) (
	input  wire logic       clk_mist,
	input  wire logic       reset,
	input  wire logic [7:0] scan_byte,
	input  wire logic       scan_valid,
	input  wire logic [7:0] joystick_0,
	input  wire logic [7:0] joystick_1,
	input  wire logic       rotate,
	output logic            up,
	output logic            down,
	output logic            left,
	output logic            right,
	output logic            fire,
	output logic            start1,
	output logic            start2,
	output logic            coin
);

	logic       key_strobe;
	logic [7:0] key_code;
	logic       key_pressed;
	logic       key_extended;
	logic [7:0] buttons;

	scan_code_fsm scan_code_fsm_i (
		.clk_mist     (clk_mist),
		.reset        (reset),
		.scan_byte    (scan_byte),
		.scan_valid   (scan_valid),
		.key_strobe   (key_strobe),
		.key_code     (key_code),
		.key_pressed  (key_pressed),
		.key_extended (key_extended)
	);

	key_button_latch key_button_latch_i (
		.clk_mist     (clk_mist),
		.reset        (reset),
		.key_strobe   (key_strobe),
		.key_code     (key_code),
		.key_pressed  (key_pressed),
		.key_extended (key_extended),
		.buttons      (buttons)
	);

	coin_pulse_timer #(
		.COIN_CYCLES (COIN_CYCLES)
	) coin_pulse_timer_i (
		.clk_mist    (clk_mist),
		.reset       (reset),
		.coin_button (buttons[arcade_ctrl_pkg::btn_coin]),
		.coin        (coin)
	);

	control_mapper control_mapper_i (
		.buttons    (buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.up         (up),
		.down       (down),
		.left       (left),
		.right      (right),
		.fire       (fire),
		.start1     (start1),
		.start2     (start2)
	);

endmodule

`default_nettype wire

/* testbench/arcade_controls_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module arcade_controls_tb;

	localparam int COIN_CYCLES = 16;
	localparam int MAX_ROWS    = 64;

	localparam logic [7:0] EXT     = arcade_ctrl_pkg::SC_EXT;
	localparam logic [7:0] BRK     = arcade_ctrl_pkg::SC_BREAK;
	localparam logic [7:0] K_UP    = arcade_ctrl_pkg::SC_UP;
	localparam logic [7:0] K_DOWN  = arcade_ctrl_pkg::SC_DOWN;
	localparam logic [7:0] K_LEFT  = arcade_ctrl_pkg::SC_LEFT;
	localparam logic [7:0] K_RIGHT = arcade_ctrl_pkg::SC_RIGHT;
	localparam logic [7:0] K_ESC   = arcade_ctrl_pkg::SC_ESC;
	localparam logic [7:0] K_F1    = arcade_ctrl_pkg::SC_F1;
	localparam logic [7:0] K_F2    = arcade_ctrl_pkg::SC_F2;
	localparam logic [7:0] K_SPACE = arcade_ctrl_pkg::SC_SPACE;
	localparam logic [7:0] K_A     = 8'h1C; // not mapped to any button

	logic       clk_mist;
	logic       reset;
	logic [7:0] scan_byte;
	logic       scan_valid;
	logic [7:0] joystick_0;
	logic [7:0] joystick_1;
	logic       rotate;
	logic       up;
	logic       down;
	logic       left;
	logic       right;
	logic       fire;
	logic       start1;
	logic       start2;
	logic       coin;

	// expected bits in order up down left right fire start1 start2
	int          row_count;
	int          row_nbytes [MAX_ROWS];
	logic [7:0]  row_byte   [3*MAX_ROWS];
	logic [7:0]  row_joy0   [MAX_ROWS];
	logic [7:0]  row_joy1   [MAX_ROWS];
	logic        row_rot    [MAX_ROWS];
	logic [6:0]  row_expect [MAX_ROWS];

	int          pass_count;
	int          fail_count;
	int unsigned seed_word;
	int          r;

	arcade_controls_top #(
		.COIN_CYCLES (COIN_CYCLES)
	) dut_i (
		.clk_mist   (clk_mist),
		.reset      (reset),
		.scan_byte  (scan_byte),
		.scan_valid (scan_valid),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.up         (up),
		.down       (down),
		.left       (left),
		.right      (right),
		.fire       (fire),
		.start1     (start1),
		.start2     (start2),
		.coin       (coin)
	);

	initial begin
		clk_mist = 1'b0;
		forever #50 clk_mist = ~clk_mist;
	end

	task automatic add_row(input int n, input logic [7:0] b0, input logic [7:0] b1,
			input logic [7:0] b2, input logic [7:0] j0, input logic [7:0] j1,
			input logic rot, input logic [6:0] exp);
		row_nbytes[row_count]     = n;
		row_byte[3*row_count]     = b0;
		row_byte[3*row_count + 1] = b1;
		row_byte[3*row_count + 2] = b2;
		row_joy0[row_count]       = j0;
		row_joy1[row_count]       = j1;
		row_rot[row_count]        = rot;
		row_expect[row_count]     = exp;
		row_count++;
	endtask

	task automatic build_table();
		row_count = 0;
		add_row(0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000000); // right after reset
		add_row(2, EXT, K_UP, 8'h00, 8'h00, 8'h00, 1'b0, 7'b1000000);
		add_row(3, EXT, BRK, K_UP, 8'h00, 8'h00, 1'b0, 7'b0000000);
		add_row(2, EXT, K_DOWN, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0100000);
		add_row(3, EXT, BRK, K_DOWN, 8'h00, 8'h00, 1'b0, 7'b0000000);
		add_row(2, EXT, K_LEFT, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0010000);
		add_row(3, EXT, BRK, K_LEFT, 8'h00, 8'h00, 1'b0, 7'b0000000);
		add_row(2, EXT, K_RIGHT, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0001000);
		add_row(3, EXT, BRK, K_RIGHT, 8'h00, 8'h00, 1'b0, 7'b0000000);
		add_row(1, K_SPACE, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000100);
		add_row(2, BRK, K_SPACE, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000000);
		add_row(1, K_F1, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000010);
		add_row(1, K_F2, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000011);
		add_row(2, BRK, K_F1, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000001);
		add_row(2, BRK, K_F2, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000000);
		add_row(1, K_UP, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000000); // keypad 8 without E0
		add_row(2, EXT, K_UP, 8'h00, 8'h00, 8'h00, 1'b0, 7'b1000000);
		add_row(2, BRK, K_UP, 8'h00, 8'h00, 8'h00, 1'b0, 7'b1000000); // plain release ignored
		add_row(3, EXT, BRK, K_UP, 8'h00, 8'h00, 1'b0, 7'b0000000);
		// joysticks OR in
		add_row(0, 8'h00, 8'h00, 8'h00, 8'h08, 8'h00, 1'b0, 7'b1000000);
		add_row(0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h01, 1'b0, 7'b0001000);
		add_row(0, 8'h00, 8'h00, 8'h00, 8'h10, 8'h00, 1'b0, 7'b0000100);
		add_row(2, EXT, K_DOWN, 8'h00, 8'h00, 8'h04, 1'b0, 7'b0100000);
		add_row(3, EXT, BRK, K_DOWN, 8'h00, 8'h04, 1'b0, 7'b0100000); // stick still down
		add_row(2, EXT, K_RIGHT, 8'h00, 8'h08, 8'h00, 1'b0, 7'b1001000);
		add_row(3, EXT, BRK, K_RIGHT, 8'h00, 8'h00, 1'b0, 7'b0000000);
		// rotated cabinet
		add_row(2, EXT, K_RIGHT, 8'h00, 8'h00, 8'h00, 1'b1, 7'b1000000);
		add_row(3, EXT, BRK, K_RIGHT, 8'h00, 8'h00, 1'b1, 7'b0000000);
		add_row(2, EXT, K_LEFT, 8'h00, 8'h00, 8'h00, 1'b1, 7'b0100000);
		add_row(3, EXT, BRK, K_LEFT, 8'h00, 8'h00, 1'b1, 7'b0000000);
		add_row(2, EXT, K_UP, 8'h00, 8'h00, 8'h00, 1'b1, 7'b0010000);
		add_row(3, EXT, BRK, K_UP, 8'h00, 8'h00, 1'b1, 7'b0000000);
		add_row(2, EXT, K_DOWN, 8'h00, 8'h00, 8'h00, 1'b1, 7'b0001000);
		add_row(3, EXT, BRK, K_DOWN, 8'h00, 8'h00, 1'b1, 7'b0000000);
		add_row(0, 8'h00, 8'h00, 8'h00, 8'h01, 8'h00, 1'b1, 7'b1000000);
		add_row(0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h02, 1'b1, 7'b0100000);
		add_row(0, 8'h00, 8'h00, 8'h00, 8'h08, 8'h00, 1'b1, 7'b0010000);
		add_row(0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h04, 1'b1, 7'b0001000);
		add_row(0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000000);
		// unlisted codes and split prefixes
		add_row(1, K_A, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000000);
		add_row(2, EXT, K_A, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000000);
		add_row(1, K_SPACE, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000100);
		add_row(2, EXT, K_SPACE, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000100);
		add_row(1, BRK, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000100); // break pending
		add_row(1, K_SPACE, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000000);
		add_row(1, EXT, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000000);
		add_row(1, K_UP, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 7'b1000000);
		add_row(2, EXT, BRK, 8'h00, 8'h00, 8'h00, 1'b0, 7'b1000000);
		add_row(1, K_UP, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 7'b0000000);
	endtask

	task automatic idle_cycle();
		@(posedge clk_mist);
		#10;
	endtask

	// one byte with a single-cycle valid strobe
	task automatic send_byte(input logic [7:0] b);
		scan_byte  = b;
		scan_valid = 1'b1;
		idle_cycle();
		scan_valid = 1'b0;
		scan_byte  = 8'h00;
	endtask

	task automatic report_test(input bit ok, input string name);
		if (ok) begin
			pass_count++;
			$display("%s: pass", name);
		end else begin
			fail_count++;
			$display("%s: FAIL", name);
		end
	endtask

	task automatic apply_row(input int idx);
		logic [31:0] rnd;
		logic [6:0]  got;
		bit          ok;
		int          k;
		ok  = 1'b1;
		rnd = $urandom;
		joystick_0 = row_joy0[idx] | (rnd[7:0] & 8'he0); // bits 7:5 are don't care
		joystick_1 = row_joy1[idx] | (rnd[15:8] & 8'he0);
		rotate     = row_rot[idx];
		for (k = 0; k < row_nbytes[idx]; k++) begin
			send_byte(row_byte[3*idx + k]);
		end
		idle_cycle();
		idle_cycle();
		got = {up, down, left, right, fire, start1, start2};
		assert (got === row_expect[idx]) else begin
			$display("[ERROR] %0t ns: row %0d outputs %b, expected %b",
				$time, idx, got, row_expect[idx]);
			ok = 1'b0;
		end
		assert (coin === 1'b0) else begin
			$display("[ERROR] %0t ns: row %0d coin is %b, expected 0", $time, idx, coin);
			ok = 1'b0;
		end
		report_test(ok, $sformatf("row %0d", idx));
	endtask

	task automatic run_coin_test(input bit repress, input string name);
		bit ok;
		bit stayed_low;
		int width;
		int n;
		ok         = 1'b1;
		stayed_low = 1'b1;
		width      = 0;
		send_byte(K_ESC);
		n = 0;
		while (coin !== 1'b1 && n < 20) begin
			idle_cycle();
			n++;
		end
		assert (coin === 1'b1) else begin
			$display("%0t ns: coin did not rise within 20 cycles of the Esc press", $time);
			ok = 1'b0;
		end
		if (coin === 1'b1) begin
			while (coin === 1'b1 && width < 64) begin
				if (repress && width == 1)
					send_byte(BRK); // release while the pulse runs
				else if (repress && width == 2)
					send_byte(K_ESC);
				else if (repress && width == 4)
					send_byte(K_ESC); // press again
				else
					idle_cycle();
				width++;
			end
			assert (coin !== 1'b1) else begin
				$display("%0t ns: coin was still high after 64 cycles", $time);
				ok = 1'b0;
			end
			assert (width == COIN_CYCLES) else begin
				$display("[ERROR] %0t ns: coin pulse was %0d cycles, expected %0d",
					$time, width, COIN_CYCLES);
				ok = 1'b0;
			end
		end
		repeat (6) begin
			idle_cycle();
			stayed_low = stayed_low & (coin === 1'b0);
		end
		assert (stayed_low) else begin
			$display("[ERROR] %0t ns: coin rose again after the pulse ended", $time);
			ok = 1'b0;
		end
		send_byte(BRK);
		send_byte(K_ESC);
		idle_cycle();
		idle_cycle();
		report_test(ok, name);
	endtask

	initial begin
		reset      = 1'b1;
		scan_byte  = 8'h00;
		scan_valid = 1'b0;
		joystick_0 = 8'h00;
		joystick_1 = 8'h00;
		rotate     = 1'b0;
		pass_count = 0;
		fail_count = 0;
		seed_word  = 32'hb498aac2;
		void'($urandom(seed_word));
		build_table();
		repeat (4) @(posedge clk_mist);
		#10;
		reset = 1'b0;
		for (r = 0; r < row_count; r++) begin
			apply_row(r);
		end
		joystick_0 = 8'h00;
		joystick_1 = 8'h00;
		rotate     = 1'b0;
		run_coin_test(1'b1, "coin pulse with re-press");
		run_coin_test(1'b0, "coin pulse after previous one");
		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
source/arcade_ctrl_pkg.sv
source/scan_code_fsm.sv
source/key_button_latch.sv
source/coin_pulse_timer.sv
source/control_mapper.sv
source/arcade_controls_top.sv
testbench/arcade_controls_tb.sv
